//--- build.f
+incdir+.
mem_pkg.sv
mem_ram_sdp_sync.sv
mem_ram_sdp_sync_wrapper.sv
mem_ram_sdp_chk.sv
tb_clk_gen.sv
tb_mem_ram_sdp.sv

//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Address width, 64 words of storage
`define MEM_ADDR_WID 6

// Word width
`define MEM_DATA_WID 16

// Wrapper input sample to wrapper ack output, in cycles
`define MEM_PORT_LAT 3

`endif

//--- mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

    // Write port inputs
    typedef struct packed {
        logic                     rst;
        logic                     en;
        logic                     req;
        logic [`MEM_ADDR_WID-1:0] addr;
        logic [`MEM_DATA_WID-1:0] data;
    } mem_wr_req_t;

    // Write port outputs
    typedef struct packed {
        logic rdy;
        logic ack;
    } mem_wr_rsp_t;

    // Read port inputs
    typedef struct packed {
        logic                     rst;
        logic                     en;
        logic                     req;
        logic [`MEM_ADDR_WID-1:0] addr;
    } mem_rd_req_t;

    // Read port outputs, data valid with ack
    typedef struct packed {
        logic                     rdy;
        logic                     ack;
        logic [`MEM_DATA_WID-1:0] data;
    } mem_rd_rsp_t;

    // Initialisation sequencer
    typedef enum logic [1:0] {
        INIT_RESET,
        INIT_CLEAR,
        INIT_DONE
    } init_state_e;

endpackage

//--- mem_ram_sdp_chk.sv
`include "mem_params.svh"

module mem_ram_sdp_chk (
    input logic                 clk,
    input logic                 srst,
    input logic                 init_done,
    input logic                 ram_init_done,
    input mem_pkg::mem_wr_req_t wr_in_q,
    input mem_pkg::mem_rd_req_t rd_in_q,
    input mem_pkg::mem_wr_rsp_t wr_out,
    input mem_pkg::mem_rd_rsp_t rd_out
);

    int fail_cnt = 0;

    logic wr_acc;
    logic rd_acc;

    // Acceptance at the RAM, one cycle after the wrapper samples the request
    assign wr_acc = wr_in_q.req && wr_in_q.en && !wr_in_q.rst && ram_init_done;
    assign rd_acc = rd_in_q.req && rd_in_q.en && !rd_in_q.rst && ram_init_done;

    a_wr_ack_follows: assert property (@(posedge clk) disable iff (srst)
        wr_acc |-> ##(`MEM_PORT_LAT - 1) wr_out.ack)
        else begin
            fail_cnt++;
            $error("write ack missing after an accepted write");
        end

    a_wr_ack_source: assert property (@(posedge clk) disable iff (srst)
        wr_out.ack |-> $past(wr_acc, `MEM_PORT_LAT - 1))
        else begin
            fail_cnt++;
            $error("write ack without an accepted write");
        end

    a_rd_ack_follows: assert property (@(posedge clk) disable iff (srst)
        rd_acc |-> ##(`MEM_PORT_LAT - 1) rd_out.ack)
        else begin
            fail_cnt++;
            $error("read ack missing after an accepted read");
        end

    a_rd_ack_source: assert property (@(posedge clk) disable iff (srst)
        rd_out.ack |-> $past(rd_acc, `MEM_PORT_LAT - 1))
        else begin
            fail_cnt++;
            $error("read ack without an accepted read");
        end

    a_init_stays: assert property (@(posedge clk) disable iff (srst)
        !$fell(init_done))
        else begin
            fail_cnt++;
            $error("init_done fell outside reset");
        end

    a_reset_quiet: assert property (@(posedge clk)
        $past(srst) |-> !init_done && !wr_out.rdy && !wr_out.ack && !rd_out.rdy && !rd_out.ack)
        else begin
            fail_cnt++;
            $error("outputs active in the cycle after reset");
        end

endmodule

//--- mem_ram_sdp_sync.sv
`include "mem_params.svh"

module mem_ram_sdp_sync #(
    parameter bit reset_fsm = 1'b1
) (
    input  logic                 clk,
    input  logic                 srst,

    output logic                 init_done,

    input  mem_pkg::mem_wr_req_t wr_req,
    output mem_pkg::mem_wr_rsp_t wr_rsp,

    input  mem_pkg::mem_rd_req_t rd_req,
    output mem_pkg::mem_rd_rsp_t rd_rsp
);

    localparam int mem_depth = 1 << `MEM_ADDR_WID;

    // Top of the array, end of the clear walk
    localparam logic [`MEM_ADDR_WID-1:0] last_addr = '1;

    mem_pkg::init_state_e init_state;
    logic [`MEM_ADDR_WID-1:0] clr_addr;
    logic clr_active;

    logic wr_rdy;
    logic wr_acc;
    logic wr_ack_q;

    logic rd_rdy;
    logic rd_acc;
    logic rd_ack_q;
    logic [`MEM_DATA_WID-1:0] rd_data_q;

    // Array write side, shared by the sequencer and the write port
    logic arr_we;
    logic [`MEM_ADDR_WID-1:0] arr_waddr;
    logic [`MEM_DATA_WID-1:0] arr_wdata;

    logic [`MEM_DATA_WID-1:0] mem [mem_depth];

    // Initialisation sequencer
    always_ff @(posedge clk) begin
        if (srst) begin
            init_state <= mem_pkg::INIT_RESET;
            clr_addr   <= '0;
        end else begin
            case (init_state)
                mem_pkg::INIT_RESET: begin
                    clr_addr <= '0;
                    // Without the clear walk the contents stay undefined
                    if (reset_fsm) begin
                        init_state <= mem_pkg::INIT_CLEAR;
                    end else begin
                        init_state <= mem_pkg::INIT_DONE;
                    end
                end
                mem_pkg::INIT_CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == last_addr) begin
                        init_state <= mem_pkg::INIT_DONE;
                    end
                end
                mem_pkg::INIT_DONE: begin
                    init_state <= mem_pkg::INIT_DONE;
                end
                default: begin
                    init_state <= mem_pkg::INIT_RESET;
                end
            endcase
        end
    end

    assign clr_active = (init_state == mem_pkg::INIT_CLEAR);
    assign init_done  = (init_state == mem_pkg::INIT_DONE);

    // Port availability and accepted requests
    assign wr_rdy = init_done && !wr_req.rst;
    assign rd_rdy = init_done && !rd_req.rst;

    assign wr_acc = wr_req.req && wr_req.en && wr_rdy;
    assign rd_acc = rd_req.req && rd_req.en && rd_rdy;

    // Sequencer owns the write side while clearing
    always_comb begin
        if (clr_active) begin
            arr_we    = 1'b1;
            arr_waddr = clr_addr;
            arr_wdata = '0;
        end else begin
            arr_we    = wr_acc;
            arr_waddr = wr_req.addr;
            arr_wdata = wr_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (arr_we) begin
            mem[arr_waddr] <= arr_wdata;
        end
    end

    // Read-first, a same-cycle write to this address lands after the read
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_data_q <= mem[rd_req.addr];
        end
    end

    // One-cycle ack pulses, cleared by the port reset
    always_ff @(posedge clk) begin
        if (srst || wr_req.rst) begin
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= wr_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (srst || rd_req.rst) begin
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= rd_acc;
        end
    end

    assign wr_rsp.rdy  = wr_rdy;
    assign wr_rsp.ack  = wr_ack_q;

    assign rd_rsp.rdy  = rd_rdy;
    assign rd_rsp.ack  = rd_ack_q;
    assign rd_rsp.data = rd_data_q;

endmodule

//--- mem_ram_sdp_sync_wrapper.sv
`include "mem_params.svh"

module mem_ram_sdp_sync_wrapper #(
    parameter bit reset_fsm = 1'b1
) (
    input  logic                 clk,
    input  logic                 srst,

    output logic                 init_done,

    input  mem_pkg::mem_wr_req_t wr_in,
    output mem_pkg::mem_wr_rsp_t wr_out,

    input  mem_pkg::mem_rd_req_t rd_in,
    output mem_pkg::mem_rd_rsp_t rd_out
);

    mem_pkg::mem_wr_req_t wr_in_q;
    mem_pkg::mem_rd_req_t rd_in_q;

    mem_pkg::mem_wr_rsp_t wr_rsp;
    mem_pkg::mem_rd_rsp_t rd_rsp;

    logic ram_init_done;

    // Input stage, payload fields carry no reset
    always_ff @(posedge clk) begin
        wr_in_q.addr <= wr_in.addr;
        wr_in_q.data <= wr_in.data;
        if (srst) begin
            wr_in_q.rst <= 1'b0;
            wr_in_q.en  <= 1'b0;
            wr_in_q.req <= 1'b0;
        end else begin
            wr_in_q.rst <= wr_in.rst;
            wr_in_q.en  <= wr_in.en;
            wr_in_q.req <= wr_in.req;
        end
    end

    always_ff @(posedge clk) begin
        rd_in_q.addr <= rd_in.addr;
        if (srst) begin
            rd_in_q.rst <= 1'b0;
            rd_in_q.en  <= 1'b0;
            rd_in_q.req <= 1'b0;
        end else begin
            rd_in_q.rst <= rd_in.rst;
            rd_in_q.en  <= rd_in.en;
            rd_in_q.req <= rd_in.req;
        end
    end

    mem_ram_sdp_sync #(
        .reset_fsm ( reset_fsm )
    ) i_mem_ram_sdp_sync (
        .clk       ( clk ),
        .srst      ( srst ),
        .init_done ( ram_init_done ),
        .wr_req    ( wr_in_q ),
        .wr_rsp    ( wr_rsp ),
        .rd_req    ( rd_in_q ),
        .rd_rsp    ( rd_rsp )
    );

    // Output stage
    always_ff @(posedge clk) begin
        if (srst) begin
            init_done  <= 1'b0;
            wr_out.rdy <= 1'b0;
            wr_out.ack <= 1'b0;
        end else begin
            init_done  <= ram_init_done;
            wr_out.rdy <= wr_rsp.rdy;
            wr_out.ack <= wr_rsp.ack;
        end
    end

    // Read data follows its ack through the same stage
    always_ff @(posedge clk) begin
        rd_out.data <= rd_rsp.data;
        if (srst) begin
            rd_out.rdy <= 1'b0;
            rd_out.ack <= 1'b0;
        end else begin
            rd_out.rdy <= rd_rsp.rdy;
            rd_out.ack <= rd_rsp.ack;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run with Verilator, then look for a failure in the log
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_mem_ram_sdp -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
exit 0

//--- tb_clk_gen.sv
module tb_clk_gen #(
    parameter int period     = 20,
    parameter int rst_cycles = 16
) (
    output logic clk,
    output logic srst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset released just after an edge, like the other inputs
    initial begin
        srst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2;
        srst = 1'b0;
    end

endmodule

//--- tb_mem_ram_sdp.sv
`include "mem_params.svh"

module tb_mem_ram_sdp;

    localparam int addr_wid = `MEM_ADDR_WID;
    localparam int data_wid = `MEM_DATA_WID;
    localparam int depth    = 1 << addr_wid;
    localparam int timeout  = 200;

    typedef logic [addr_wid-1:0] addr_t;
    typedef logic [data_wid-1:0] data_t;

    logic clk;
    logic srst;
    logic init_done;

    mem_pkg::mem_wr_req_t wr_in;
    mem_pkg::mem_wr_rsp_t wr_out;
    mem_pkg::mem_rd_req_t rd_in;
    mem_pkg::mem_rd_rsp_t rd_out;

    int seed = 80;
    logic [31:0] rnd;

    data_t ref_mem [depth];
    data_t exp_data[$];
    addr_t exp_addr[$];
    addr_t addr_list [32];
    data_t head_data;
    addr_t head_addr;

    int wr_exp_cnt = 0;
    int rd_exp_cnt = 0;
    int wr_ack_cnt = 0;
    int rd_ack_cnt = 0;
    int err_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int mark;

    tb_clk_gen #(
        .period     ( 20 ),
        .rst_cycles ( 16 )
    ) i_clk_gen (
        .clk  ( clk ),
        .srst ( srst )
    );

    mem_ram_sdp_sync_wrapper #(
        .reset_fsm ( 1'b1 )
    ) DUT (
        .clk       ( clk ),
        .srst      ( srst ),
        .init_done ( init_done ),
        .wr_in     ( wr_in ),
        .wr_out    ( wr_out ),
        .rd_in     ( rd_in ),
        .rd_out    ( rd_out )
    );

    bind mem_ram_sdp_sync_wrapper mem_ram_sdp_chk i_chk (
        .clk           ( clk ),
        .srst          ( srst ),
        .init_done     ( init_done ),
        .ram_init_done ( ram_init_done ),
        .wr_in_q       ( wr_in_q ),
        .rd_in_q       ( rd_in_q ),
        .wr_out        ( wr_out ),
        .rd_out        ( rd_out )
    );

    // Response monitor sees the values from before the edge
    always @(posedge clk) begin
        if (!srst) begin
            if (wr_out.ack) begin
                wr_ack_cnt++;
            end
            if (rd_out.ack) begin
                rd_ack_cnt++;
                if (exp_data.size() == 0) begin
                    $display("read ack arrived at %0t with no read pending", $time);
                    err_cnt++;
                end else begin
                    head_data = exp_data.pop_front();
                    head_addr = exp_addr.pop_front();
                    if (rd_out.data !== head_data) begin
                        $display("error at %0t: read of address %0d returned %h, expected %h",
                                 $time, head_addr, rd_out.data, head_data);
                        err_cnt++;
                    end
                end
            end
        end
    end

    function automatic int fault_total();
        return err_cnt + DUT.i_chk.fail_cnt;
    endfunction

    // Drives one cycle and updates the reference model read-first
    task automatic issue(input logic w_req, input logic w_en, input addr_t w_addr,
                         input data_t w_data, input logic r_req, input logic r_en,
                         input addr_t r_addr);
        wr_in.req  = w_req;
        wr_in.en   = w_en;
        wr_in.addr = w_addr;
        wr_in.data = w_data;
        rd_in.req  = r_req;
        rd_in.en   = r_en;
        rd_in.addr = r_addr;
        if (r_req && r_en && !rd_in.rst) begin
            exp_data.push_back(ref_mem[r_addr]);
            exp_addr.push_back(r_addr);
            rd_exp_cnt++;
        end
        if (w_req && w_en && !wr_in.rst) begin
            ref_mem[w_addr] = w_data;
            wr_exp_cnt++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycle();
        issue(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic read_all();
        for (int i = 0; i < depth; i++) begin
            issue(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(i));
        end
    endtask

    // Wait for every expected ack, then watch a few cycles for extras
    task automatic drain();
        int t;
        t = 0;
        idle_cycle();
        while ((wr_ack_cnt != wr_exp_cnt || rd_ack_cnt != rd_exp_cnt) && t < timeout) begin
            idle_cycle();
            t++;
        end
        if (t >= timeout) begin
            $display("timeout: acks still missing after %0d cycles", timeout);
            err_cnt++;
        end
        repeat (`MEM_PORT_LAT + 2) idle_cycle();
        if (wr_ack_cnt != wr_exp_cnt || rd_ack_cnt != rd_exp_cnt) begin
            $display("ack count differs from the number of accepted requests");
            err_cnt++;
        end
    endtask

    task automatic wait_rdy(input bit wr_port, input logic level);
        int t;
        t = 0;
        while ((wr_port ? wr_out.rdy : rd_out.rdy) !== level && t < timeout) begin
            idle_cycle();
            t++;
        end
        if (t >= timeout) begin
            $display("timeout: port rdy did not reach the expected level");
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (fault_total() != mark) begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        mark = fault_total();
    endtask

    initial begin
        int t;
        wr_in = '0;
        rd_in = '0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        mark = 0;

        // Initialisation clear
        t = 0;
        @(posedge clk);
        #2;
        while (!init_done && t < timeout) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!init_done) begin
            $display("timeout: init_done never rose");
            err_cnt++;
        end
        read_all();
        drain();
        report_test("init clear");

        // Write then read back
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            addr_list[i] = rnd[addr_wid-1:0];
            rnd = $random(seed);
            issue(1'b1, 1'b1, addr_list[i], rnd[data_wid-1:0], 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 32; i++) begin
            issue(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_list[i]);
        end
        drain();
        report_test("write read back");

        // Pipelined traffic on both ports
        // Small address range gives same-address collisions
        for (int i = 0; i < 48; i++) begin
            rnd = $random(seed);
            issue(1'b1, 1'b1, addr_t'(rnd[2:0]), rnd[31:16], 1'b1, 1'b1, addr_t'(rnd[5:3]));
        end
        issue(1'b1, 1'b1, addr_t'(5), 16'hbeef, 1'b1, 1'b1, addr_t'(5));
        issue(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(5));
        drain();
        report_test("pipelined traffic");

        // Enable low
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            issue(1'b1, 1'b0, addr_t'(i), rnd[15:0], 1'b1, 1'b0, addr_t'(i));
        end
        for (int i = 0; i < 16; i++) begin
            issue(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(i));
        end
        drain();
        report_test("enable low");

        // Port reset on the read port and then the write port
        rd_in.rst = 1'b1;
        wait_rdy(1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            issue(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(i));
        end
        rd_in.rst = 1'b0;
        wait_rdy(1'b0, 1'b1);
        wr_in.rst = 1'b1;
        wait_rdy(1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            issue(1'b1, 1'b1, addr_t'(i), rnd[15:0], 1'b0, 1'b0, '0);
        end
        wr_in.rst = 1'b0;
        wait_rdy(1'b1, 1'b1);
        // Write port back in service, away from the blocked addresses
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            issue(1'b1, 1'b1, addr_t'(32 + i), rnd[15:0], 1'b0, 1'b0, '0);
        end
        read_all();
        drain();
        report_test("port reset");

        $display("tests run %0d, failed %0d, data errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, DUT.i_chk.fail_cnt);
        if (tests_failed == 0 && fault_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
